//--- dv/sudoku_tests.svh
`ifndef SUDOKU_TESTS_SVH
`define SUDOKU_TESTS_SVH
`default_nettype none

task automatic after_reset();
  if (status.busy !== 1'b0) flag_error("status_o.busy", status.busy, 1'b0);
  if (status.solved !== 1'b0) flag_error("status_o.solved", status.solved, 1'b0);
  if (status.stuck !== 1'b0) flag_error("status_o.stuck", status.stuck, 1'b0);
  if (req_ready !== 1'b1) flag_error("req_ready_o", req_ready, 1'b1);
  if (rsp_valid !== 1'b0) flag_error("rsp_valid_o", rsp_valid, 1'b0);
endtask

task automatic row_readback();
  row_mask_t   written [GRID_N];
  logic [31:0] rnd;
  for (int r = 0; r < GRID_N; r++) begin
    for (int c = 0; c < GRID_N; c++) begin
      rnd           = $random(seed);
      written[r][c] = rnd[GRID_N-1:0];
    end
    write_row(r, written[r]);
  end
  for (int r = 0; r < GRID_N; r++) begin
    read_row(r, written[r], (r % 3 == 1) ? 4 : 0);  // every third read is held
  end
endtask

task automatic solve_one_pass();
  row_mask_t puzzle;
  int        cycles;
  for (int r = 0; r < GRID_N; r++) begin
    puzzle    = solution_row(r);
    puzzle[r] = ALL_DIGITS;  // blanks on the diagonal
    write_row(r, puzzle);
  end
  run_solve(1'b1, 4, cycles);
  // one blank per row is settled by the row masks alone
  if (cycles != PASS_CYCLES) count_error("status_o.busy cycles", cycles, PASS_CYCLES);
  take_rsp(solution_row(4), 0, "rsp_o row 4 read offered during the run");
  if (status.solved !== 1'b1) flag_error("status_o.solved", status.solved, 1'b1);
  if (status.stuck !== 1'b0) flag_error("status_o.stuck", status.stuck, 1'b0);
  for (int r = 0; r < GRID_N; r++) begin
    read_row(r, solution_row(r), 0);
  end
endtask

task automatic stuck_on_blank();
  int cycles;
  for (int r = 0; r < GRID_N; r++) begin
    write_row(r, '1);
  end
  run_solve(1'b0, 0, cycles);
  if (cycles != PASS_CYCLES) count_error("status_o.busy cycles", cycles, PASS_CYCLES);
  if (status.stuck !== 1'b1) flag_error("status_o.stuck", status.stuck, 1'b1);
  if (status.solved !== 1'b0) flag_error("status_o.solved", status.solved, 1'b0);
  for (int r = 0; r < GRID_N; r++) begin
    read_row(r, '1, 0);
  end
endtask

task automatic abort_mid_run();
  pulse_start();
  @(negedge clk);
  if (!status.busy) fail_note("start on the blank grid did not raise busy");
  @(posedge clk);
  #DRIVE_DLY abort = 1'b1;
  @(posedge clk);
  #DRIVE_DLY abort = 1'b0;
  @(negedge clk);
  if (status.busy !== 1'b0) flag_error("status_o.busy", status.busy, 1'b0);
  if (status.stuck !== 1'b0) flag_error("status_o.stuck", status.stuck, 1'b0);
  @(posedge clk);
  #DRIVE_DLY;
endtask

task automatic start_when_solved();
  for (int r = 0; r < GRID_N; r++) begin
    write_row(r, solution_row(r));
  end
  if (status.solved !== 1'b1) flag_error("status_o.solved", status.solved, 1'b1);
  pulse_start();
  repeat (4) begin
    @(negedge clk);
    if (status.busy) fail_note("start raised busy on a solved grid");
  end
  @(posedge clk);
  #DRIVE_DLY;
endtask

`default_nettype wire
`endif

//--- dv/tb_sudoku.sv
`default_nettype none

module tb_sudoku
  import sudoku_pkg::*;
();

  timeunit 1ns;
  timeprecision 100ps;

  // three solve runs of at most 81 passes of 16 cycles, plus host traffic and margin
  localparam int TIMEOUT_CYCLES = 24000;
  localparam int HALF_PERIOD    = 4;
  localparam int DRIVE_DLY      = 1;
  localparam int PASS_CYCLES    = 16;  // open, nine rows, three boxes, column, commit, check

  logic      clk = 1'b0;
  logic      reset;
  host_req_t req;
  logic      req_valid;
  logic      req_ready;
  row_mask_t rsp;
  logic      rsp_valid;
  logic      rsp_ready;
  logic      start;
  logic      abort;
  status_t   status;

  int value_errs;
  int other_fails;
  int cycle_cnt = 0;
  int seed;

  sudoku_solver DUT (
    .clk         (clk),
    .reset       (reset),
    .req_i       (req),
    .req_valid_i (req_valid),
    .req_ready_o (req_ready),
    .rsp_o       (rsp),
    .rsp_valid_o (rsp_valid),
    .rsp_ready_i (rsp_ready),
    .start_i     (start),
    .abort_i     (abort),
    .status_o    (status)
  );

  always #HALF_PERIOD clk = ~clk;

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("*** FAILED ***");
      $finish;
    end
  end

  // reference solution row, each digit coded one-hot
  function automatic row_mask_t solution_row(input int r);
    row_mask_t row;
    int        d;
    for (int c = 0; c < GRID_N; c++) begin
      d      = (3 * r + r / 3 + c) % GRID_N;
      row[c] = digit_mask_t'(1) << d;
    end
    return row;
  endfunction

  task automatic mask_error(input string name, input row_mask_t got, input row_mask_t exp);
    $display("Error: %s got %h expected %h", name, got, exp);
    value_errs++;
  endtask

  task automatic flag_error(input string name, input logic got, input logic exp);
    $display("Error: %s got %h expected %h", name, got, exp);
    value_errs++;
  endtask

  task automatic count_error(input string name, input int got, input int exp);
    $display("Error: %s got %h expected %h", name, got, exp);
    value_errs++;
  endtask

  task automatic fail_note(input string what);
    $display("failure: %s", what);
    other_fails++;
  endtask

  task automatic send_req(input logic write, input int row, input row_mask_t data);
    req.write = write;
    req.row   = row_idx_t'(row);
    req.data  = data;
    req_valid = 1'b1;
    do begin
      @(negedge clk);
    end while (!req_ready);
    @(posedge clk);  // transfer happens on this edge
    #DRIVE_DLY req_valid = 1'b0;
  endtask

  task automatic take_rsp(input row_mask_t exp, input int hold, input string name);
    row_mask_t first;
    @(negedge clk);
    if (!rsp_valid) fail_note({name, ": no response on the cycle after the read"});
    first = rsp;
    if (first !== exp) mask_error(name, first, exp);
    repeat (hold) begin
      @(negedge clk);
      if (!rsp_valid) fail_note({name, ": response dropped while held"});
      if (rsp !== first) mask_error({name, " while held"}, rsp, first);
    end
    @(posedge clk);
    #DRIVE_DLY rsp_ready = 1'b1;
    @(posedge clk);
    #DRIVE_DLY rsp_ready = 1'b0;
  endtask

  task automatic write_row(input int row, input row_mask_t data);
    send_req(1'b1, row, data);
  endtask

  task automatic read_row(input int row, input row_mask_t exp, input int hold);
    send_req(1'b0, row, '0);
    take_rsp(exp, hold, $sformatf("rsp_o row %0d", row));
  endtask

  task automatic pulse_start();
    start = 1'b1;
    @(posedge clk);
    #DRIVE_DLY start = 1'b0;
  endtask

  // start a run and wait for busy to fall, optionally offering a read meanwhile
  task automatic run_solve(input logic offer_read, input int rd_row, output int cycles);
    cycles = 0;
    pulse_start();
    if (offer_read) begin
      req       = '0;
      req.row   = row_idx_t'(rd_row);
      req_valid = 1'b1;
    end
    @(negedge clk);
    if (!status.busy) fail_note("start did not raise busy");
    while (status.busy) begin
      if (req_ready || rsp_valid) fail_note("host request accepted during a run");
      @(negedge clk);
      cycles++;
    end
    if (offer_read && !req_ready) fail_note("request still held off after busy fell");
    @(posedge clk);
    #DRIVE_DLY req_valid = 1'b0;
  endtask

  initial begin
    seed        = 14;
    reset       = 1'b1;
    req         = '0;
    req_valid   = 1'b0;
    rsp_ready   = 1'b0;
    start       = 1'b0;
    abort       = 1'b0;
    value_errs  = 0;
    other_fails = 0;
    repeat (16) @(posedge clk);
    #DRIVE_DLY reset = 1'b0;

    after_reset();
    row_readback();
    solve_one_pass();
    stuck_on_blank();
    abort_mid_run();
    start_when_solved();

    $display("value errors %0d, other failures %0d", value_errs, other_fails);
    if (value_errs == 0 && other_fails == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

  `include "sudoku_tests.svh"

endmodule

`default_nettype wire

//--- rtl/constraint_sweep.sv
`default_nettype none

module constraint_sweep
  import sudoku_pkg::*;
(
  input  wire                         clk,
  input  wire                         reset,
  input  wire                         start_i,
  input  wire                         abort_i,
  input  wire row_mask_t [GRID_N-1:0] fixed_i,
  input  wire                         grid_solved_i,
  input  wire                         grid_changed_i,
  output grid_cmd_t                   cmd_o,
  output status_t                     status_o
);

  typedef enum logic [2:0] {
    S_IDLE,
    S_OPEN,
    S_ROW,
    S_BOX,
    S_COL,
    S_COMMIT,
    S_CHECK
  } sweep_state_e;

  sweep_state_e            state_q;
  row_idx_t                row_q;
  logic                    stuck_q;
  row_mask_t               col_acc_q;  // digits placed per column so far
  digit_mask_t [BOX_N-1:0] box_acc_q;  // digits placed per box in this band

  row_mask_t               row_fixed;
  digit_mask_t             row_seen;
  row_mask_t               col_next;
  digit_mask_t [BOX_N-1:0] box_next;
  logic                    band_end;

  assign row_fixed = fixed_i[row_q];
  assign band_end  = (row_q % BOX_N) == BOX_N - 1;

  always_comb begin
    row_seen = '0;
    col_next = col_acc_q;
    box_next = box_acc_q;
    for (int k = 0; k < GRID_N; k++) begin
      row_seen             = row_seen | row_fixed[k];
      col_next[k]          = col_next[k] | row_fixed[k];
      box_next[k / BOX_N]  = box_next[k / BOX_N] | row_fixed[k];
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state_q <= S_IDLE;
      row_q   <= '0;
      stuck_q <= 1'b0;
    end else if (abort_i) begin
      state_q <= S_IDLE;
      stuck_q <= 1'b0;
    end else begin
      case (state_q)
        S_IDLE: begin
          if (start_i && !grid_solved_i) begin
            state_q <= S_OPEN;
            stuck_q <= 1'b0;
          end
        end
        S_OPEN: begin
          row_q   <= '0;
          state_q <= S_ROW;
        end
        S_ROW: begin
          if (band_end) begin
            state_q <= S_BOX;
          end else begin
            row_q <= row_q + 1'b1;
          end
        end
        S_BOX: begin
          if (row_q == GRID_N - 1) begin
            state_q <= S_COL;
          end else begin
            row_q   <= row_q + 1'b1;
            state_q <= S_ROW;
          end
        end
        S_COL:    state_q <= S_COMMIT;
        S_COMMIT: state_q <= S_CHECK;
        S_CHECK: begin
          if (grid_solved_i) begin
            state_q <= S_IDLE;
          end else if (!grid_changed_i) begin
            state_q <= S_IDLE;
            stuck_q <= 1'b1;  // a whole pass without progress
          end else begin
            state_q <= S_OPEN;
          end
        end
        default: state_q <= S_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state_q == S_OPEN) begin
      col_acc_q <= '0;
      box_acc_q <= '0;
    end else if (state_q == S_ROW) begin
      col_acc_q <= col_next;
      box_acc_q <= box_next;
    end else if (state_q == S_BOX) begin
      box_acc_q <= '0;  // next band starts clean
    end
  end

  always_comb begin
    cmd_o    = '0;
    cmd_o.op = CELL_NOP;
    case (state_q)
      S_OPEN: begin
        cmd_o.op     = CELL_OPEN;
        cmd_o.row_en = '1;
      end
      S_ROW: begin
        cmd_o.op     = CELL_RESTRICT;
        cmd_o.row_en = row_sel_t'(1) << row_q;
        for (int k = 0; k < GRID_N; k++) begin
          cmd_o.mask[k] = ~row_seen;
        end
      end
      S_BOX: begin
        // row_q is the last row of the band here
        cmd_o.op     = CELL_RESTRICT;
        cmd_o.row_en = row_sel_t'({BOX_N{1'b1}}) << (row_q - row_idx_t'(BOX_N - 1));
        for (int k = 0; k < GRID_N; k++) begin
          cmd_o.mask[k] = ~box_acc_q[k / BOX_N];
        end
      end
      S_COL: begin
        cmd_o.op     = CELL_RESTRICT;
        cmd_o.row_en = '1;
        cmd_o.mask   = ~col_acc_q;
      end
      S_COMMIT: begin
        cmd_o.op     = CELL_COMMIT;
        cmd_o.row_en = '1;
      end
      default: cmd_o.op = CELL_NOP;
    endcase
  end

  assign status_o.busy   = state_q != S_IDLE;
  assign status_o.solved = grid_solved_i;
  assign status_o.stuck  = stuck_q;

  a_idle_nop: assert property (
    @(posedge clk) disable iff (reset)
    !status_o.busy |-> cmd_o.op == CELL_NOP
  );

endmodule

`default_nettype wire

//--- rtl/host_port.sv
`default_nettype none

module host_port
  import sudoku_pkg::*;
(
  input  wire                         clk,
  input  wire                         reset,
  input  wire host_req_t              req_i,
  input  wire                         req_valid_i,
  output logic                        req_ready_o,
  output row_mask_t                   rsp_o,
  output logic                        rsp_valid_o,
  input  wire                         rsp_ready_i,
  input  wire row_mask_t [GRID_N-1:0] cand_i,
  input  wire                         busy_i,
  input  wire grid_cmd_t              sweep_cmd_i,
  output grid_cmd_t                   cmd_o
);

  logic      req_fire;
  logic      rd_fire;
  logic      rsp_valid_q;
  row_mask_t rsp_q;

  assign req_ready_o = !busy_i && !rsp_valid_q;  // one read in flight at most
  assign req_fire    = req_valid_i && req_ready_o;
  assign rd_fire     = req_fire && !req_i.write;
  assign rsp_o       = rsp_q;
  assign rsp_valid_o = rsp_valid_q;

  always_comb begin
    if (busy_i) begin
      cmd_o = sweep_cmd_i;
    end else begin
      cmd_o    = '0;
      cmd_o.op = CELL_NOP;
      if (req_fire && req_i.write) begin
        cmd_o.op     = CELL_LOAD;
        cmd_o.row_en = row_sel_t'(1) << req_i.row;
        cmd_o.mask   = req_i.data;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      rsp_valid_q <= 1'b0;
    end else if (rd_fire) begin
      rsp_valid_q <= 1'b1;
    end else if (rsp_ready_i) begin
      rsp_valid_q <= 1'b0;
    end
  end

  // captured so a later solve cannot disturb a held response
  always_ff @(posedge clk) begin
    if (rd_fire) begin
      rsp_q <= cand_i[req_i.row];
    end
  end

  a_no_req_busy: assert property (
    @(posedge clk) disable iff (reset)
    busy_i |-> !req_ready_o
  );

endmodule

`default_nettype wire

//--- rtl/sudoku_cell.sv
`default_nettype none

module sudoku_cell
  import sudoku_pkg::*;
(
  input  wire              clk,
  input  wire              reset,
  input  wire cell_op_e    op_i,
  input  wire digit_mask_t mask_i,
  output digit_mask_t      cand_o,
  output digit_mask_t      fixed_o,
  output logic             solved_o,
  output logic             changed_o
);

  digit_mask_t cand_q;
  digit_mask_t allow_q;
  digit_mask_t narrowed;
  logic        changed_q;

  assign narrowed = cand_q & allow_q;

  // exactly one digit left
  assign solved_o  = (cand_q != '0) && ((cand_q & (cand_q - 1'b1)) == '0);
  assign fixed_o   = solved_o ? cand_q : '0;
  assign cand_o    = cand_q;
  assign changed_o = changed_q;

  always_ff @(posedge clk) begin
    if (reset) begin
      cand_q    <= ALL_DIGITS;
      changed_q <= 1'b0;
    end else if (op_i == CELL_LOAD) begin
      cand_q <= mask_i;
    end else if (op_i == CELL_COMMIT) begin
      if (solved_o) begin
        changed_q <= 1'b0;  // a placed digit is never narrowed
      end else begin
        cand_q    <= narrowed;
        changed_q <= narrowed != cand_q;
      end
    end
  end

  always_ff @(posedge clk) begin
    case (op_i)
      CELL_OPEN:     allow_q <= ALL_DIGITS;
      CELL_RESTRICT: allow_q <= allow_q & mask_i;
      default:       allow_q <= allow_q;
    endcase
  end

  a_commit_shrinks: assert property (
    @(posedge clk) disable iff (reset)
    op_i == CELL_COMMIT |=> (cand_q & ~$past(cand_q)) == '0
  );

endmodule

`default_nettype wire

//--- rtl/sudoku_pkg.sv
`default_nettype none

package sudoku_pkg;

  localparam int GRID_N = 9;
  localparam int BOX_N  = 3;

  // bit k set means digit k+1 is still possible
  typedef logic [GRID_N-1:0] digit_mask_t;

  localparam digit_mask_t ALL_DIGITS = '1;

  typedef digit_mask_t [GRID_N-1:0] row_mask_t;  // element 0 is column 0
  typedef logic [GRID_N-1:0]        row_sel_t;
  typedef logic [3:0]               row_idx_t;

  typedef enum logic [2:0] {
    CELL_NOP      = 3'd0,
    CELL_LOAD     = 3'd1,  // candidates take the mask
    CELL_OPEN     = 3'd2,  // allowed mask back to all digits
    CELL_RESTRICT = 3'd3,  // allowed &= mask
    CELL_COMMIT   = 3'd4   // unsolved candidates &= allowed
  } cell_op_e;

  // command broadcast to every row
  typedef struct packed {
    cell_op_e  op;
    row_sel_t  row_en;
    row_mask_t mask;
  } grid_cmd_t;

  typedef struct packed {
    logic      write;
    row_idx_t  row;
    row_mask_t data;
  } host_req_t;

  typedef struct packed {
    logic busy;
    logic solved;
    logic stuck;
  } status_t;

endpackage

`default_nettype wire

//--- rtl/sudoku_row.sv
`default_nettype none

module sudoku_row
  import sudoku_pkg::*;
(
  input  wire            clk,
  input  wire            reset,
  input  wire grid_cmd_t cmd_i,
  input  wire            row_en_i,
  output row_mask_t      cand_o,
  output row_mask_t      fixed_o,
  output logic           solved_o,
  output logic           changed_o
);

  cell_op_e cell_op;
  row_sel_t cell_solved;
  row_sel_t cell_changed;

  assign cell_op = row_en_i ? cmd_i.op : CELL_NOP;  // other rows sit still

  for (genvar c = 0; c < GRID_N; c++) begin : g_cell
    sudoku_cell u_cell (
      .clk       (clk),
      .reset     (reset),
      .op_i      (cell_op),
      .mask_i    (cmd_i.mask[c]),
      .cand_o    (cand_o[c]),
      .fixed_o   (fixed_o[c]),
      .solved_o  (cell_solved[c]),
      .changed_o (cell_changed[c])
    );
  end

  assign solved_o  = &cell_solved;
  assign changed_o = |cell_changed;

endmodule

`default_nettype wire

//--- rtl/sudoku_solver.sv
`default_nettype none

module sudoku_solver
  import sudoku_pkg::*;
(
  input  wire            clk,
  input  wire            reset,
  input  wire host_req_t req_i,
  input  wire            req_valid_i,
  output logic           req_ready_o,
  output row_mask_t      rsp_o,
  output logic           rsp_valid_o,
  input  wire            rsp_ready_i,
  input  wire            start_i,
  input  wire            abort_i,
  output status_t        status_o
);

  grid_cmd_t              grid_cmd;   // what every row sees
  grid_cmd_t              sweep_cmd;
  status_t                sweep_status;
  row_mask_t [GRID_N-1:0] row_cand;
  row_mask_t [GRID_N-1:0] row_fixed;
  row_sel_t               row_solved;
  row_sel_t               row_changed;
  logic                   grid_solved;
  logic                   grid_changed;

  for (genvar r = 0; r < GRID_N; r++) begin : g_row
    sudoku_row u_row (
      .clk       (clk),
      .reset     (reset),
      .cmd_i     (grid_cmd),
      .row_en_i  (grid_cmd.row_en[r]),
      .cand_o    (row_cand[r]),
      .fixed_o   (row_fixed[r]),
      .solved_o  (row_solved[r]),
      .changed_o (row_changed[r])
    );
  end

  assign grid_solved  = &row_solved;
  assign grid_changed = |row_changed;

  constraint_sweep u_sweep (
    .clk            (clk),
    .reset          (reset),
    .start_i        (start_i),
    .abort_i        (abort_i),
    .fixed_i        (row_fixed),
    .grid_solved_i  (grid_solved),
    .grid_changed_i (grid_changed),
    .cmd_o          (sweep_cmd),
    .status_o       (sweep_status)
  );

  host_port u_host (
    .clk         (clk),
    .reset       (reset),
    .req_i       (req_i),
    .req_valid_i (req_valid_i),
    .req_ready_o (req_ready_o),
    .rsp_o       (rsp_o),
    .rsp_valid_o (rsp_valid_o),
    .rsp_ready_i (rsp_ready_i),
    .cand_i      (row_cand),
    .busy_i      (sweep_status.busy),
    .sweep_cmd_i (sweep_cmd),
    .cmd_o       (grid_cmd)
  );

  assign status_o = sweep_status;

endmodule

`default_nettype wire

//--- run.sh
#!/bin/sh
# build tb_sudoku with Verilator, run it and look for the pass line in the log

cd "$(dirname "$0")" || exit 1

OBJ_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/100ps \
  --top-module tb_sudoku -Mdir "$OBJ_DIR" -f tb.f
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

"./$OBJ_DIR/Vtb_sudoku" > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if grep -q -F '*** PASSED ***' "$LOG"; then
  exit 0
fi
echo "pass line not found in $LOG"
exit 1

//--- tb.f
+incdir+dv
rtl/sudoku_pkg.sv
rtl/sudoku_cell.sv
rtl/sudoku_row.sv
rtl/constraint_sweep.sv
rtl/host_port.sv
rtl/sudoku_solver.sv
dv/tb_sudoku.sv
